// ==== design/lb_pkg.sv ====
package lb_pkg;

    // Bus widths
    localparam int LB_UP_ADR_W  = 22;           // Upstream word address
    localparam int LB_DWN_ADR_W = 16;           // Downstream word address
    localparam int LB_DATA_W    = 32;           // Data word
    localparam int GPIO_W       = 16;           // General purpose in/out

    // Port select field
    localparam int LB_PORTS   = 2;              // Downstream ports
    localparam int LB_SEL_LSB = 16;             // First select bit in upstream address
    localparam int LB_SEL_W   = $clog2(LB_PORTS);

    // Scratch RAM geometry
    localparam int RAM_DEPTH = 256;             // Words
    localparam int RAM_ADR_W = $clog2(RAM_DEPTH);

    // Vector types
    typedef logic [LB_UP_ADR_W-1:0]  lb_up_adr_t;
    typedef logic [LB_DWN_ADR_W-1:0] lb_dwn_adr_t;
    typedef logic [LB_DATA_W-1:0]    lb_data_t;
    typedef logic [GPIO_W-1:0]       gpio_t;
    typedef logic [LB_SEL_W-1:0]     lb_sel_t;
    typedef logic [RAM_ADR_W-1:0]    ram_adr_t;

    // Register map of the control block
    localparam lb_dwn_adr_t REG_GPIO_OUT = 16'd0;   // RW, gpio output
    localparam lb_dwn_adr_t REG_GPIO_IN  = 16'd1;   // RO, synchronised gpio input
    localparam lb_dwn_adr_t REG_SCRATCH  = 16'd2;   // RW, 32-bit scratch
    localparam lb_dwn_adr_t REG_VERSION  = 16'd3;   // RO, version word

    // Version constant, major 1 minor 2
    localparam lb_data_t VERSION_WORD = 32'h0001_0002;

endpackage

// ==== design/lb_mux.sv ====
module lb_mux
    import lb_pkg::*;
(
    input  logic                CLK_IN,                 // Clock
    input  logic                rst_n,                  // Sync reset, active low

    // Upstream master
    input  lb_up_adr_t          up_adr,                 // Word address
    input  lb_data_t            up_din,                 // Write data
    input  logic                up_wr,                  // Write strobe, level
    input  logic                up_rd,                  // Read strobe, level
    output lb_data_t            up_dout,                // Read data
    output logic                up_vld,                 // Read data valid

    // Downstream ports
    output lb_dwn_adr_t         dwn_adr,                // Shared address
    output lb_data_t            dwn_wdat,               // Shared write data
    output logic [LB_PORTS-1:0] dwn_wr,                 // Write pulse per port
    output logic [LB_PORTS-1:0] dwn_rd,                 // Read pulse per port
    input  lb_data_t            dwn_rdat [LB_PORTS],    // Read data per port
    input  logic [LB_PORTS-1:0] dwn_vld                 // Read valid per port
);

    // Registered upstream inputs
    lb_up_adr_t          up_adr_q;
    lb_data_t            up_din_q;
    logic                up_wr_q;
    logic                up_rd_q;

    // Strobe history for the edge detectors
    logic                up_wr_d;
    logic                up_rd_d;
    logic                wr_re;                         // Write rising edge
    logic                rd_re;                         // Read rising edge

    // Port select
    lb_sel_t             sel;
    logic [LB_PORTS-1:0] port_en;                       // One-hot

    // Return path
    lb_data_t            sel_rdat;
    logic                sel_vld;
    lb_data_t            up_dout_q;
    logic                up_vld_q;

    // Address and data are payload, sampled every cycle
    always_ff @(posedge CLK_IN)
    begin
        up_adr_q <= up_adr;
        up_din_q <= up_din;
    end

    // Strobes and their history
    always_ff @(posedge CLK_IN)
    begin
        if (!rst_n)
        begin
            up_wr_q <= 1'b0;
            up_rd_q <= 1'b0;
            up_wr_d <= 1'b0;
            up_rd_d <= 1'b0;
        end
        else
        begin
            up_wr_q <= up_wr;                           // Sample edge E0
            up_rd_q <= up_rd;
            up_wr_d <= up_wr_q;                         // One cycle later
            up_rd_d <= up_rd_q;
        end
    end

    // High for the single cycle after E0
    assign wr_re = up_wr_q & ~up_wr_d;
    assign rd_re = up_rd_q & ~up_rd_d;

    // Select field, upper address bits beyond it ignored
    assign sel = up_adr_q[LB_SEL_LSB +: LB_SEL_W];

    always_comb
    begin
        for (int i = 0; i < LB_PORTS; i++)
        begin
            port_en[i] = (sel == lb_sel_t'(i));
        end
    end

    // Pulses go to the selected port only
    assign dwn_wr = port_en & {LB_PORTS{wr_re}};
    assign dwn_rd = port_en & {LB_PORTS{rd_re}};

    // Common to all ports
    assign dwn_adr  = up_adr_q[LB_DWN_ADR_W-1:0];
    assign dwn_wdat = up_din_q;

    // Pick the return of the enabled port
    always_comb
    begin
        sel_rdat = '0;
        sel_vld  = 1'b0;
        for (int i = 0; i < LB_PORTS; i++)
        begin
            if (port_en[i])
            begin
                sel_rdat = dwn_rdat[i];
                sel_vld  = dwn_vld[i];
            end
        end
    end

    // Valid back to the master, one cycle wide
    always_ff @(posedge CLK_IN)
    begin
        if (!rst_n)
            up_vld_q <= 1'b0;
        else
            up_vld_q <= sel_vld;
    end

    // Read data holds between reads
    always_ff @(posedge CLK_IN)
    begin
        if (sel_vld)
            up_dout_q <= sel_rdat;
    end

    assign up_dout = up_dout_q;
    assign up_vld  = up_vld_q;

endmodule

// ==== design/lb_ctrl_regs.sv ====
module lb_ctrl_regs
    import lb_pkg::*;
(
    input  logic        CLK_IN,         // Clock
    input  logic        rst_n,          // Sync reset, active low

    // Local bus slave
    input  lb_dwn_adr_t adr,            // Word address
    input  lb_data_t    wdat,           // Write data
    input  logic        wr,             // Write pulse
    input  logic        rd,             // Read pulse
    output lb_data_t    rdat,           // Read data
    output logic        vld,            // Read data valid

    // General purpose I/O
    input  gpio_t       gpio_in,        // Asynchronous input
    output gpio_t       gpio_out        // Registered output
);

    // Writable registers
    gpio_t       gpio_out_q;
    lb_data_t    scratch_q;

    // Two-flop synchroniser for gpio_in
    gpio_t       gpio_meta;
    gpio_t       gpio_sync;

    // Read side
    lb_data_t    rd_mux;
    lb_data_t    rdat_q;
    logic        vld_q;

    // Register writes, read-only and unmapped addresses dropped
    always_ff @(posedge CLK_IN)
    begin
        if (!rst_n)
        begin
            gpio_out_q <= '0;
            scratch_q  <= '0;
        end
        else if (wr)
        begin
            case (adr)
                REG_GPIO_OUT : gpio_out_q <= wdat[GPIO_W-1:0];   // Low half only
                REG_SCRATCH  : scratch_q  <= wdat;
                default      : ;                                  // No effect
            endcase
        end
    end

    // Synchroniser, value usable after the second stage
    always_ff @(posedge CLK_IN)
    begin
        if (!rst_n)
        begin
            gpio_meta <= '0;
            gpio_sync <= '0;
        end
        else
        begin
            gpio_meta <= gpio_in;
            gpio_sync <= gpio_meta;
        end
    end

    // Read decode
    always_comb
    begin
        case (adr)
            REG_GPIO_OUT : rd_mux = lb_data_t'(gpio_out_q);    // Zero-extended
            REG_GPIO_IN  : rd_mux = lb_data_t'(gpio_sync);     // Zero-extended
            REG_SCRATCH  : rd_mux = scratch_q;
            REG_VERSION  : rd_mux = VERSION_WORD;
            default      : rd_mux = '0;                        // Unmapped reads zero
        endcase
    end

    // Read data captured on the rd pulse
    always_ff @(posedge CLK_IN)
    begin
        if (rd)
            rdat_q <= rd_mux;
    end

    // Valid one cycle after rd
    always_ff @(posedge CLK_IN)
    begin
        if (!rst_n)
            vld_q <= 1'b0;
        else
            vld_q <= rd;
    end

    assign rdat     = rdat_q;
    assign vld      = vld_q;
    assign gpio_out = gpio_out_q;

endmodule

// ==== design/lb_scratch_ram.sv ====
module lb_scratch_ram
    import lb_pkg::*;
(
    input  logic        CLK_IN,         // Clock
    input  logic        rst_n,          // Sync reset, active low

    // Local bus slave
    input  lb_dwn_adr_t adr,            // Word address, low bits used
    input  lb_data_t    wdat,           // Write data
    input  logic        wr,             // Write pulse
    input  logic        rd,             // Read pulse
    output lb_data_t    rdat,           // Read data
    output logic        vld             // Read data valid
);

    // Storage, no reset
    lb_data_t    mem [RAM_DEPTH];

    // Address aliasing, upper bits ignored
    ram_adr_t    ram_adr;

    // Read pipeline
    ram_adr_t    rd_adr_q;              // Stage 1 address
    logic        rd_q;                  // Stage 1 valid
    lb_data_t    rdat_q;                // Stage 2 data
    logic        vld_q;                 // Stage 2 valid

    assign ram_adr = adr[RAM_ADR_W-1:0];

    // Write port
    always_ff @(posedge CLK_IN)
    begin
        if (wr)
            mem[ram_adr] <= wdat;
    end

    // Stage 1, latch read address
    always_ff @(posedge CLK_IN)
    begin
        if (rd)
            rd_adr_q <= ram_adr;
    end

    // Stage 2, array read into output register
    always_ff @(posedge CLK_IN)
    begin
        if (rd_q)
            rdat_q <= mem[rd_adr_q];
    end

    // Valid follows the two stages
    always_ff @(posedge CLK_IN)
    begin
        if (!rst_n)
        begin
            rd_q  <= 1'b0;
            vld_q <= 1'b0;
        end
        else
        begin
            rd_q  <= rd;
            vld_q <= rd_q;
        end
    end

    assign rdat = rdat_q;
    assign vld  = vld_q;

endmodule

// ==== design/lb_subsys_top.sv ====
module lb_subsys_top
    import lb_pkg::*;
(
    input  logic        CLK_IN,         // Clock
    input  logic        rst_n,          // Sync reset, active low

    // Upstream local bus
    input  lb_up_adr_t  adr,            // Word address
    input  lb_data_t    din,            // Write data
    input  logic        wr,             // Write strobe
    input  logic        rd,             // Read strobe
    output lb_data_t    dout,           // Read data
    output logic        vld,            // Read data valid

    // General purpose I/O
    input  gpio_t       gpio_in,
    output gpio_t       gpio_out
);

    // Downstream fabric
    lb_dwn_adr_t         dwn_adr;
    lb_data_t            dwn_wdat;
    logic [LB_PORTS-1:0] dwn_wr;
    logic [LB_PORTS-1:0] dwn_rd;
    lb_data_t            dwn_rdat [LB_PORTS];
    logic [LB_PORTS-1:0] dwn_vld;

    // Bus multiplexer
    lb_mux mux0
    (
        .CLK_IN   (CLK_IN),
        .rst_n    (rst_n),
        .up_adr   (adr),
        .up_din   (din),
        .up_wr    (wr),
        .up_rd    (rd),
        .up_dout  (dout),
        .up_vld   (vld),
        .dwn_adr  (dwn_adr),
        .dwn_wdat (dwn_wdat),
        .dwn_wr   (dwn_wr),
        .dwn_rd   (dwn_rd),
        .dwn_rdat (dwn_rdat),
        .dwn_vld  (dwn_vld)
    );

    // Port 0, control and status registers
    lb_ctrl_regs regs0
    (
        .CLK_IN   (CLK_IN),
        .rst_n    (rst_n),
        .adr      (dwn_adr),
        .wdat     (dwn_wdat),
        .wr       (dwn_wr[0]),
        .rd       (dwn_rd[0]),
        .rdat     (dwn_rdat[0]),
        .vld      (dwn_vld[0]),
        .gpio_in  (gpio_in),
        .gpio_out (gpio_out)
    );

    // Port 1, scratch RAM
    lb_scratch_ram ram0
    (
        .CLK_IN   (CLK_IN),
        .rst_n    (rst_n),
        .adr      (dwn_adr),
        .wdat     (dwn_wdat),
        .wr       (dwn_wr[1]),
        .rd       (dwn_rd[1]),
        .rdat     (dwn_rdat[1]),
        .vld      (dwn_vld[1])
    );

endmodule

// ==== verification/lb_checker.sv ====
module lb_checker
    import lb_pkg::*;
(
    input  logic       CLK_IN,
    input  logic       rst_n,
    input  lb_up_adr_t adr,
    input  lb_data_t   din,
    input  logic       wr,
    input  logic       rd,
    input  lb_data_t   dout,
    input  logic       vld,
    input  gpio_t      gpio_in,
    input  gpio_t      gpio_out,
    input  lb_data_t   exp_dat,         // Table value for the current read
    output int         err_cnt
);
    timeunit 1ns;
    timeprecision 100ps;

    // Shadow model built from observed writes
    gpio_t      gpio_m;
    lb_data_t   scratch_m;
    lb_data_t   ram_m [RAM_DEPTH];
    bit         ram_known [RAM_DEPTH];
    gpio_t      gpio_d1;                // gpio_out lags the write by two edges
    gpio_t      gpio_d2;
    logic       wr_q;
    logic       rd_q;
    bit         pending;                // Read waiting for vld
    int         lat;
    int         lat_exp;
    lb_data_t   model_dat;
    lb_data_t   table_dat;
    lb_up_adr_t rd_adr;

    // Expected read data per the register map
    function automatic lb_data_t model_read(input lb_up_adr_t a);
        if (a[LB_SEL_LSB])
            return ram_m[a[RAM_ADR_W-1:0]];         // Aliases modulo 256
        case (a[LB_DWN_ADR_W-1:0])
            REG_GPIO_OUT : return {16'h0, gpio_m};
            REG_GPIO_IN  : return {16'h0, gpio_in};   // Held long enough to be synced
            REG_SCRATCH  : return scratch_m;
            REG_VERSION  : return VERSION_WORD;
            default      : return '0;
        endcase
    endfunction

    initial err_cnt = 0;

    always @(posedge CLK_IN)
    begin
        if (!rst_n)
        begin
            gpio_m    = '0;
            scratch_m = '0;
            gpio_d1   = '0;
            gpio_d2   = '0;
            wr_q      = 1'b0;
            rd_q      = 1'b0;
            pending   = 1'b0;
            foreach (ram_known[k])
                ram_known[k] = 1'b0;
        end
        else
        begin
            if (gpio_out !== gpio_d2)
            begin
                $display("Fail %0t ns: gpio_out %h, expected %h", $time, gpio_out, gpio_d2);
                err_cnt++;
            end
            if (pending)
                lat++;
            if (vld === 1'b1 && !pending)
            begin
                $display("Error: vld pulse at %0t ns with no read outstanding", $time);
                err_cnt++;
            end
            else if (vld === 1'b1)
            begin
                if (dout !== model_dat || dout !== table_dat)
                begin
                    $display("Fail %0t ns: read %h returned %h, model %h, table %h",
                             $time, rd_adr, dout, model_dat, table_dat);
                    err_cnt++;
                end
                if (lat - 1 != lat_exp)             // vld seen one edge after it rose
                begin
                    $display("Fail %0t ns: read %h latency %0d, expected %0d",
                             $time, rd_adr, lat - 1, lat_exp);
                    err_cnt++;
                end
                pending = 1'b0;
            end
            if (pending && ((wr && !wr_q) || (rd && !rd_q)))
            begin
                $display("Error: read of %h never returned before the next access", rd_adr);
                err_cnt++;
                pending = 1'b0;
            end
            if (wr && !wr_q && adr[LB_SEL_LSB])
            begin
                ram_m[adr[RAM_ADR_W-1:0]]     = din;
                ram_known[adr[RAM_ADR_W-1:0]] = 1'b1;
            end
            else if (wr && !wr_q && adr[LB_DWN_ADR_W-1:0] == REG_GPIO_OUT)
                gpio_m = din[GPIO_W-1:0];
            else if (wr && !wr_q && adr[LB_DWN_ADR_W-1:0] == REG_SCRATCH)
                scratch_m = din;
            if (rd && !rd_q)
            begin
                if (adr[LB_SEL_LSB] && !ram_known[adr[RAM_ADR_W-1:0]])
                begin
                    $display("Error: read of RAM word %h that was never written", adr);
                    err_cnt++;
                end
                rd_adr    = adr;
                model_dat = model_read(adr);
                table_dat = exp_dat;
                lat       = 0;
                lat_exp   = adr[LB_SEL_LSB] ? 3 : 2;   // RAM has the extra stage
                pending   = 1'b1;
            end
            wr_q    = wr;
            rd_q    = rd;
            gpio_d2 = gpio_d1;
            gpio_d1 = gpio_m;
        end
    end

endmodule

// ==== verification/lb_subsys_assert.sv ====
module lb_subsys_assert
    import lb_pkg::*;
(
    input logic  CLK_IN,
    input logic  rst_n,
    input logic  wr,
    input logic  rd,
    input logic  vld,
    input gpio_t gpio_out
);
    timeunit 1ns;
    timeprecision 100ps;

    int fail_cnt = 0;                   // Failed assertions

    // Single-cycle valid
    vld_one_cycle: assert property (@(posedge CLK_IN) disable iff (!rst_n) vld |=> !vld)
        else
        begin
            $error("vld high for two cycles");
            fail_cnt++;
        end

    // Quiet bus during reset
    vld_in_reset: assert property (@(posedge CLK_IN) (!rst_n && $past(!rst_n)) |-> !vld)
        else
        begin
            $error("vld high during reset");
            fail_cnt++;
        end

    // Strobe is held until vld, so rd was high three edges back
    vld_after_rd: assert property (@(posedge CLK_IN) disable iff (!rst_n) vld |-> $past(rd, 3))
        else
        begin
            $error("vld without a read");
            fail_cnt++;
        end

    // gpio_out moves two edges after the sampled write
    gpio_stable: assert property (@(posedge CLK_IN) disable iff (!rst_n)
        (gpio_out != $past(gpio_out)) |-> $past(wr, 2))
        else
        begin
            $error("gpio_out changed without a write");
            fail_cnt++;
        end

endmodule

bind lb_subsys_top lb_subsys_assert assert0
(
    .CLK_IN   (CLK_IN),
    .rst_n    (rst_n),
    .wr       (wr),
    .rd       (rd),
    .vld      (vld),
    .gpio_out (gpio_out)
);

// ==== verification/tb_lb_subsys.sv ====
module tb_lb_subsys
    import lb_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    typedef enum bit {OP_RD, OP_WR} op_t;

    logic       CLK_IN;
    logic       rst_n;
    lb_up_adr_t adr;
    lb_data_t   din;
    logic       wr;
    logic       rd;
    lb_data_t   dout;
    logic       vld;
    gpio_t      gpio_in;
    gpio_t      gpio_out;
    lb_data_t   exp_dat;
    int         chk_err_cnt;
    int         lost_cnt;                   // Reads that got no vld
    int         cyc = 0;
    int         cyc_limit;

    // Stimulus table, one column per queue
    op_t        tab_op [$];
    lb_up_adr_t tab_adr [$];
    lb_data_t   tab_dat [$];
    gpio_t      tab_gpio [$];
    lb_data_t   tab_exp [$];

    lb_subsys_top dut0 (.*);

    lb_checker chk0 (.err_cnt(chk_err_cnt), .*);

    always #2 CLK_IN = ~CLK_IN;             // 4 ns period

    always @(posedge CLK_IN)
    begin
        cyc <= cyc + 1;
        if (cyc_limit > 0 && cyc >= cyc_limit)
        begin
            $display("Timeout: run stopped after %0d cycles", cyc);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic add_entry(input op_t op, input lb_up_adr_t a, input lb_data_t d,
                             input gpio_t g, input lb_data_t e);
        tab_op.push_back(op);
        tab_adr.push_back(a);
        tab_dat.push_back(d);
        tab_gpio.push_back(g);
        tab_exp.push_back(e);
    endtask

    // Strobe held four cycles, then low for two
    task automatic write_access(input lb_up_adr_t a, input lb_data_t d);
        @(posedge CLK_IN);
        #1;
        adr = a;
        din = d;
        wr  = 1'b1;
        repeat (4) @(posedge CLK_IN);
        #1;
        wr = 1'b0;
        repeat (2) @(posedge CLK_IN);
    endtask

    // Strobe held until vld, or given up after 10 cycles
    task automatic read_access(input lb_up_adr_t a, input lb_data_t e);
        int wait_cyc;
        @(posedge CLK_IN);
        #1;
        adr      = a;
        exp_dat  = e;
        rd       = 1'b1;
        wait_cyc = 0;
        do
        begin
            @(posedge CLK_IN);
            wait_cyc++;
        end
        while (vld !== 1'b1 && wait_cyc < 10);
        if (vld !== 1'b1)
        begin
            $display("Error: read of %h got no vld within %0d cycles", a, wait_cyc);
            lost_cnt++;
        end
        #1;
        rd = 1'b0;
        repeat (2) @(posedge CLK_IN);
    endtask

    initial
    begin
        integer     seed;
        lb_up_adr_t rnd_adr;
        lb_data_t   rnd_dat;
        int         err_total;
        seed = 32'h36ae6f64;
        {CLK_IN, rst_n, wr, rd} = 4'b0000;
        adr       = '0;
        din       = '0;
        gpio_in   = '0;
        exp_dat   = '0;
        lost_cnt  = 0;
        add_entry(OP_RD, 22'h000000, 32'h0,         16'h0,    32'h0);          // Reset values
        add_entry(OP_RD, 22'h000002, 32'h0,         16'h0,    32'h0);
        add_entry(OP_WR, 22'h000000, 32'hdead_a5c3, 16'h0,    32'h0);
        add_entry(OP_RD, 22'h000000, 32'h0,         16'h0,    32'h0000_a5c3);
        add_entry(OP_WR, 22'h000002, 32'h1234_5678, 16'h0,    32'h0);
        add_entry(OP_RD, 22'h000002, 32'h0,         16'h0,    32'h1234_5678);
        add_entry(OP_RD, 22'h000003, 32'h0,         16'h0,    32'h0001_0002);
        add_entry(OP_WR, 22'h000003, 32'hffff_ffff, 16'h0,    32'h0);          // Read-only
        add_entry(OP_WR, 22'h000001, 32'hffff_ffff, 16'h0,    32'h0);
        add_entry(OP_WR, 22'h000004, 32'hcafe_f00d, 16'h0,    32'h0);          // Unmapped
        add_entry(OP_RD, 22'h000003, 32'h0,         16'h0,    32'h0001_0002);
        add_entry(OP_RD, 22'h000004, 32'h0,         16'h0,    32'h0);
        add_entry(OP_RD, 22'h00ffff, 32'h0,         16'h0,    32'h0);
        add_entry(OP_RD, 22'h000001, 32'h0,         16'h8a3c, 32'h0000_8a3c);
        add_entry(OP_WR, 22'h010001, 32'h2222_0001, 16'h8a3c, 32'h0);          // RAM port
        add_entry(OP_WR, 22'h0100ff, 32'h3333_00ff, 16'h8a3c, 32'h0);
        add_entry(OP_RD, 22'h010101, 32'h0,         16'h8a3c, 32'h2222_0001);  // Alias of 1
        add_entry(OP_WR, 22'h3f01ff, 32'h4444_01ff, 16'h8a3c, 32'h0);          // Upper bits set
        add_entry(OP_RD, 22'h0100ff, 32'h0,         16'h8a3c, 32'h4444_01ff);
        add_entry(OP_RD, 22'h3e0002, 32'h0,         16'h8a3c, 32'h1234_5678);
        add_entry(OP_RD, 22'h000000, 32'h0,         16'h8a3c, 32'h0000_a5c3);
        for (int n = 0; n < 6; n++)
        begin
            rnd_adr              = lb_up_adr_t'($random(seed));
            rnd_adr[LB_SEL_LSB]  = 1'b1;    // Always the RAM
            rnd_dat              = $random(seed);
            add_entry(OP_WR, rnd_adr, rnd_dat, 16'h8a3c, 32'h0);
            add_entry(OP_RD, rnd_adr, 32'h0,   16'h8a3c, rnd_dat);
        end
        cyc_limit = 40 * tab_op.size() + 8;
        repeat (8) @(posedge CLK_IN);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < tab_op.size(); i++)
        begin
            if (tab_gpio[i] !== gpio_in)
            begin
                @(posedge CLK_IN);
                #1;
                gpio_in = tab_gpio[i];
                repeat (10) @(posedge CLK_IN);      // Through the synchroniser
            end
            if (tab_op[i] == OP_WR)
                write_access(tab_adr[i], tab_dat[i]);
            else
                read_access(tab_adr[i], tab_exp[i]);
        end
        repeat (5) @(posedge CLK_IN);
        err_total = chk_err_cnt + dut0.assert0.fail_cnt + lost_cnt;
        $display("Errors: %0d checker, %0d assertion, %0d lost read",
                 chk_err_cnt, dut0.assert0.fail_cnt, lost_cnt);
        if (err_total == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== all.f ====
design/lb_pkg.sv
design/lb_mux.sv
design/lb_ctrl_regs.sv
design/lb_scratch_ram.sv
design/lb_subsys_top.sv
verification/lb_checker.sv
verification/lb_subsys_assert.sv
verification/tb_lb_subsys.sv
